// File: logic/cfg_pkg.sv
package cfg_pkg;

	// Core options and DIP switches as decoded from the host status word
	typedef struct packed {
		logic       rotate;
		logic [1:0] scanlines;
		logic       blend;
		logic       joyswap;
		logic [7:0] dip1;
		logic [7:0] dip2;
	} core_options_t;

	// Low byte of a host joystick word, right is bit 0
	typedef struct packed {
		logic coin;
		logic start;
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} player_t;

	// Control vector of the core, driven active low
	typedef struct packed {
		logic coin1;
		logic two_players;
		logic one_player;
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} controls_t;

endpackage

// File: logic/mem_pkg.sv
package mem_pkg;

	// **************************************************
	// SDRAM write built from one host download byte
	// **************************************************
	typedef struct packed {
		logic [22:0] word_addr;
		logic [1:0]  ds;       // Byte enables, high byte on bit 1
		logic [15:0] data;
		logic        we;
	} dl_write_t;

	// **************************************************
	// Word addresses for the two ROM read ports
	// **************************************************
	typedef struct packed {
		logic [13:0] cpu_addr;
		logic [14:0] spr_addr;
	} rom_word_t;

endpackage

// File: logic/status_decode.sv
module status_decode #(
	parameter logic [7:0] dip1_mask = 8'h7F
) (
	input  logic                  clock_40,
	input  logic                  rst,
	input  logic [63:0]           status,
	output cfg_pkg::core_options_t options,
	output logic                  user_reset
);
	import cfg_pkg::*;

	core_options_t opt_next;

	always_comb begin
		opt_next.rotate    = status[2];
		opt_next.scanlines = status[4:3];
		opt_next.blend     = status[5];
		opt_next.joyswap   = status[6];
		// The host keeps the DIP switches active low
		opt_next.dip1      = ~status[15:8] & dip1_mask; // Mask drops the cabinet option
		opt_next.dip2      = ~status[23:16];
	end

	always_ff @(posedge clock_40) begin
		if (rst) begin
			options    <= '0;
			user_reset <= 1'b0;
		end else begin
			options    <= opt_next;
			user_reset <= status[0]; // Reset entry of the host menu
		end
	end

endmodule

// File: logic/rom_loader.sv
module rom_loader (
	input  logic               clock_40,
	input  logic               rst,
	input  logic               ioctl_downl,
	input  logic               ioctl_wr,
	input  logic [7:0]         ioctl_index,
	input  logic [24:0]        ioctl_addr,
	input  logic [7:0]         ioctl_dout,
	input  logic               user_reset,
	input  logic               reset_button,
	output logic               port_req,
	output mem_pkg::dl_write_t dl_write,
	output logic               dn_wr,
	output logic               core_reset
);
	import mem_pkg::*;

	dl_write_t dl_next;
	logic      wr_last;
	logic      wr_rise;
	logic      downl_last;
	logic      rom_loaded;

	assign wr_rise = ioctl_wr & ~wr_last;

	// Both halves carry the same byte, the enables pick the half
	always_comb begin
		dl_next.word_addr = ioctl_addr[23:1];
		dl_next.ds        = {ioctl_addr[0], ~ioctl_addr[0]};
		dl_next.data      = {ioctl_dout, ioctl_dout};
		dl_next.we        = ioctl_downl;
	end

	// **************************************************
	// Download write requests
	// **************************************************
	always_ff @(posedge clock_40) begin
		if (rst) begin
			wr_last  <= 1'b0;
			port_req <= 1'b0;
			dn_wr    <= 1'b0;
		end else begin
			wr_last <= ioctl_wr;
			if (ioctl_downl && wr_rise)
				port_req <= ~port_req; // Each level change asks for one write
			dn_wr <= ioctl_wr & (ioctl_index == 8'd0);
		end
	end

	always_ff @(posedge clock_40) begin
		dl_write.word_addr <= dl_next.word_addr;
		dl_write.ds        <= dl_next.ds;
		dl_write.data      <= dl_next.data;
	end

	always_ff @(posedge clock_40) begin
		if (rst)
			dl_write.we <= 1'b0;
		else
			dl_write.we <= dl_next.we;
	end

	// **************************************************
	// Core reset
	// **************************************************
	always_ff @(posedge clock_40) begin
		if (rst) begin
			downl_last <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			downl_last <= ioctl_downl;
			if (downl_last && !ioctl_downl)
				rom_loaded <= 1'b1; // Stays set after the first download
			core_reset <= user_reset | reset_button | ~rom_loaded;
		end
	end

endmodule

// File: logic/input_mapper.sv
module input_mapper (
	input  logic                   clock_40,
	input  logic                   rst,
	input  logic [31:0]            joystick_0,
	input  logic [31:0]            joystick_1,
	input  cfg_pkg::core_options_t options,
	output cfg_pkg::controls_t     controls
);
	import cfg_pkg::*;

	player_t   p1;
	player_t   p2;
	controls_t ctl_next;

	// Joystick swap lets the second pad drive player 1
	always_comb begin
		if (options.joyswap) begin
			p1 = joystick_1[7:0];
			p2 = joystick_0[7:0];
		end else begin
			p1 = joystick_0[7:0];
			p2 = joystick_1[7:0];
		end
	end

	always_comb begin
		if (options.rotate) begin
			// Quarter turn for a cabinet on its side
			ctl_next.up    = p1.right;
			ctl_next.down  = p1.left;
			ctl_next.left  = p1.up;
			ctl_next.right = p1.down;
		end else begin
			ctl_next.up    = p1.up;
			ctl_next.down  = p1.down;
			ctl_next.left  = p1.left;
			ctl_next.right = p1.right;
		end
		ctl_next.fire_a      = p1.fire_a;
		ctl_next.fire_b      = p1.fire_b;
		ctl_next.one_player  = p1.start;
		ctl_next.two_players = p2.start;
		ctl_next.coin1       = p1.coin | p2.coin; // One coin slot for both pads
	end

	always_ff @(posedge clock_40) begin
		if (rst)
			controls <= '1; // Nothing pressed
		else
			controls <= ~ctl_next;
	end

endmodule

// File: logic/rom_fetch.sv
module rom_fetch #(
	parameter logic [14:0] sprite_base = 15'h3000
) (
	input  logic               clock_40,
	input  logic               rst,
	input  logic               ioctl_downl,
	input  logic [14:0]        cpu_rom_addr,
	input  logic [13:0]        spr_rom_addr,
	input  logic [15:0]        cpu_rom_word,
	input  logic [15:0]        spr_rom_word,
	output mem_pkg::rom_word_t rom_addr,
	output logic [7:0]         cpu_rom_do,
	output logic [7:0]         spr_rom_do
);
	import mem_pkg::*;

	rom_word_t addr_next;
	logic      cpu_lsb;
	logic      spr_lsb;

	always_comb begin
		if (ioctl_downl) begin
			// Read ports stay parked while the loader owns the SDRAM
			addr_next.cpu_addr = '1;
			addr_next.spr_addr = '1;
		end else begin
			addr_next.cpu_addr = cpu_rom_addr[14:1];
			addr_next.spr_addr = {2'b00, spr_rom_addr[13:1]} + sprite_base;
		end
	end

	// **************************************************
	// Stage 1 word address
	// **************************************************
	always_ff @(posedge clock_40) begin
		rom_addr <= addr_next;
		cpu_lsb  <= cpu_rom_addr[0];
		spr_lsb  <= spr_rom_addr[0];
	end

	// **************************************************
	// Stage 2 byte select
	// **************************************************
	always_ff @(posedge clock_40) begin
		if (rst) begin
			cpu_rom_do <= 8'h00;
			spr_rom_do <= 8'h00;
		end else begin
			cpu_rom_do <= cpu_lsb ? cpu_rom_word[15:8] : cpu_rom_word[7:0]; // Odd byte sits high
			spr_rom_do <= spr_lsb ? spr_rom_word[15:8] : spr_rom_word[7:0];
		end
	end

endmodule

// File: logic/arcade_ctrl_top.sv
module arcade_ctrl_top #(
	parameter logic [14:0] sprite_base = 15'h3000,
	parameter logic [7:0]  dip1_mask   = 8'h7F
) (
	input  logic                   clock_40,
	input  logic                   rst,
	input  logic [63:0]            status,
	input  logic [1:0]             buttons,
	input  logic [31:0]            joystick_0,
	input  logic [31:0]            joystick_1,
	input  logic                   ioctl_downl,
	input  logic                   ioctl_wr,
	input  logic [7:0]             ioctl_index,
	input  logic [24:0]            ioctl_addr,
	input  logic [7:0]             ioctl_dout,
	input  logic [14:0]            cpu_rom_addr,
	input  logic [13:0]            spr_rom_addr,
	input  logic [15:0]            cpu_rom_word,
	input  logic [15:0]            spr_rom_word,
	output cfg_pkg::core_options_t options,
	output cfg_pkg::controls_t     controls,
	output logic                   core_reset,
	output logic                   port_req,
	output mem_pkg::dl_write_t     dl_write,
	output logic                   dn_wr,
	output mem_pkg::rom_word_t     rom_addr,
	output logic [7:0]             cpu_rom_do,
	output logic [7:0]             spr_rom_do
);

	logic user_reset;

	status_decode #(.dip1_mask(dip1_mask)) u_status_decode (
		.clock_40   (clock_40),
		.rst        (rst),
		.status     (status),
		.options    (options),
		.user_reset (user_reset)
	);

	// One request toggle serves both SDRAM write ports
	rom_loader u_rom_loader (
		.clock_40     (clock_40),
		.rst          (rst),
		.ioctl_downl  (ioctl_downl),
		.ioctl_wr     (ioctl_wr),
		.ioctl_index  (ioctl_index),
		.ioctl_addr   (ioctl_addr),
		.ioctl_dout   (ioctl_dout),
		.user_reset   (user_reset),
		.reset_button (buttons[1]),
		.port_req     (port_req),
		.dl_write     (dl_write),
		.dn_wr        (dn_wr),
		.core_reset   (core_reset)
	);

	input_mapper u_input_mapper (
		.clock_40   (clock_40),
		.rst        (rst),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.options    (options),
		.controls   (controls)
	);

	rom_fetch #(.sprite_base(sprite_base)) u_rom_fetch (
		.clock_40     (clock_40),
		.rst          (rst),
		.ioctl_downl  (ioctl_downl),
		.cpu_rom_addr (cpu_rom_addr),
		.spr_rom_addr (spr_rom_addr),
		.cpu_rom_word (cpu_rom_word),
		.spr_rom_word (spr_rom_word),
		.rom_addr     (rom_addr),
		.cpu_rom_do   (cpu_rom_do),
		.spr_rom_do   (spr_rom_do)
	);

endmodule

// File: tests/tb_arcade_ctrl.sv
module tb_arcade_ctrl;
	timeunit 1ns;
	timeprecision 1ps;
	import cfg_pkg::*;
	import mem_pkg::*;

	localparam logic [14:0] spr_offset = 15'h3000;
	localparam logic [7:0]  dip_mask   = 8'h7F;
	localparam logic [15:0] cpu_key    = 16'hA5C3;
	localparam logic [15:0] spr_key    = 16'h5A3C;

	logic          clock_40 = 1'b0;
	logic          rst;
	logic [63:0]   status;
	logic [1:0]    buttons;
	logic [31:0]   joystick_0;
	logic [31:0]   joystick_1;
	logic          ioctl_downl;
	logic          ioctl_wr;
	logic [7:0]    ioctl_index;
	logic [24:0]   ioctl_addr;
	logic [7:0]    ioctl_dout;
	logic [14:0]   cpu_rom_addr;
	logic [13:0]   spr_rom_addr;
	logic [15:0]   cpu_rom_word;
	logic [15:0]   spr_rom_word;
	core_options_t options;
	controls_t     controls;
	logic          core_reset;
	logic          port_req;
	dl_write_t     dl_write;
	logic          dn_wr;
	rom_word_t     rom_addr;
	logic [7:0]    cpu_rom_do;
	logic [7:0]    spr_rom_do;

	// Loader inputs of the previous cycle as the model sees them
	logic [24:0]   last_addr = '0;
	logic [7:0]    last_dout = '0;
	logic [7:0]    last_index = '0;
	logic          last_wr = 1'b0;
	logic          last_downl = 1'b0;
	logic          last_req = 1'b0;
	int            toggles = 0;

	always #2 clock_40 = ~clock_40;

	arcade_ctrl_top #(.sprite_base(spr_offset), .dip1_mask(dip_mask)) dut (
		.clock_40     (clock_40),
		.rst          (rst),
		.status       (status),
		.buttons      (buttons),
		.joystick_0   (joystick_0),
		.joystick_1   (joystick_1),
		.ioctl_downl  (ioctl_downl),
		.ioctl_wr     (ioctl_wr),
		.ioctl_index  (ioctl_index),
		.ioctl_addr   (ioctl_addr),
		.ioctl_dout   (ioctl_dout),
		.cpu_rom_addr (cpu_rom_addr),
		.spr_rom_addr (spr_rom_addr),
		.cpu_rom_word (cpu_rom_word),
		.spr_rom_word (spr_rom_word),
		.options      (options),
		.controls     (controls),
		.core_reset   (core_reset),
		.port_req     (port_req),
		.dl_write     (dl_write),
		.dn_wr        (dn_wr),
		.rom_addr     (rom_addr),
		.cpu_rom_do   (cpu_rom_do),
		.spr_rom_do   (spr_rom_do)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected)
			abort_run($sformatf("mismatch at %0t: %s expected %0h actual %0h",
				$time, name, expected, actual));
	endtask

	// Each SDRAM word is its own address scrambled by a key
	function automatic logic [15:0] sdram_word(input logic [14:0] addr, input logic [15:0] key);
		return {1'b0, addr} ^ key;
	endfunction

	function automatic logic [7:0] pick_byte(input logic [15:0] word, input logic odd);
		return odd ? word[15:8] : word[7:0];
	endfunction

	function automatic logic [8:0] expect_controls(input logic [31:0] j0, input logic [31:0] j1,
			input logic rotate, input logic swap);
		logic [7:0] a;
		logic [7:0] b;
		logic [3:0] dir;
		a = swap ? j1[7:0] : j0[7:0];
		b = swap ? j0[7:0] : j1[7:0];
		// Pad bits from 0 up are right, left, down, up, fire_a, fire_b, start, coin
		if (rotate)
			dir = {a[0], a[1], a[3], a[2]};
		else
			dir = {a[3], a[2], a[1], a[0]};
		return ~{a[7] | b[7], b[6], a[6], a[5], a[4], dir};
	endfunction

	// **************************************************
	// One loader cycle with random address, data and index
	// **************************************************
	task automatic step_loader(input logic downl, input logic wr);
		logic [24:0] addr;
		logic [7:0]  dout;
		logic [7:0]  index;
		addr  = 25'($urandom);
		dout  = 8'($urandom);
		index = ($urandom_range(1) == 0) ? 8'd0 : 8'($urandom);
		@(posedge clock_40);
		ioctl_downl <= downl;
		ioctl_wr    <= wr;
		ioctl_index <= index;
		ioctl_addr  <= addr;
		ioctl_dout  <= dout;
		@(negedge clock_40);
		check_value("dl_write.word_addr", 64'(last_addr[23:1]), 64'(dl_write.word_addr));
		check_value("dl_write.ds", 64'({last_addr[0], ~last_addr[0]}), 64'(dl_write.ds));
		check_value("dl_write.data", 64'({last_dout, last_dout}), 64'(dl_write.data));
		check_value("dl_write.we", 64'(last_downl), 64'(dl_write.we));
		check_value("dn_wr", 64'(last_wr && last_index == 8'd0), 64'(dn_wr));
		if (port_req !== last_req)
			toggles++;
		last_req   = port_req;
		last_addr  = addr;
		last_dout  = dout;
		last_index = index;
		last_wr    = wr;
		last_downl = downl;
	endtask

	task automatic decode_status_words();
		logic [63:0] st;
		logic [63:0] prev;
		prev = status;
		for (int n = 0; n < 200; n++) begin
			st = {$urandom, $urandom};
			@(posedge clock_40);
			status <= st;
			@(negedge clock_40);
			check_value("options.rotate", 64'(prev[2]), 64'(options.rotate));
			check_value("options.scanlines", 64'(prev[4:3]), 64'(options.scanlines));
			check_value("options.blend", 64'(prev[5]), 64'(options.blend));
			check_value("options.joyswap", 64'(prev[6]), 64'(options.joyswap));
			check_value("options.dip1", 64'(~prev[15:8] & dip_mask), 64'(options.dip1));
			check_value("options.dip2", 64'(prev[23:16] ^ 8'hFF), 64'(options.dip2));
			prev = st;
		end
		@(posedge clock_40);
		status <= '0; // Keeps the menu reset low for the download
	endtask

	task automatic load_rom_burst();
		int gap;
		int wait_cycles;
		step_loader(1'b1, 1'b0);
		for (int n = 0; n < 64; n++) begin
			step_loader(1'b1, 1'b1);
			gap = $urandom_range(3, 1);
			for (int g = 0; g < gap; g++)
				step_loader(1'b1, 1'b0);
		end
		wait_cycles = 0;
		while (toggles < 64) begin
			if (wait_cycles == 8) begin
				abort_run("port_req stopped toggling before every download pulse was seen");
			end else begin
				step_loader(1'b1, 1'b0);
				wait_cycles++;
			end
		end
		check_value("port_req toggles", 64'd64, 64'(toggles));
		step_loader(1'b0, 1'b0);
		wait_cycles = 0;
		while (core_reset !== 1'b0) begin
			if (wait_cycles == 10) begin
				abort_run("core_reset stayed high after the download ended");
			end else begin
				step_loader(1'b0, 1'b0);
				wait_cycles++;
			end
		end
		check_value("core_reset release delay", 64'd2, 64'(wait_cycles));
	endtask

	// Menu reset passes two registers, the button only one
	task automatic follow_reset_sources();
		logic s_now;
		logic b_now;
		logic s_d1;
		logic s_d2;
		logic b_d1;
		s_d1 = 1'b0;
		s_d2 = 1'b0;
		b_d1 = 1'b0;
		for (int n = 0; n < 40; n++) begin
			s_now = 1'($urandom_range(1));
			b_now = ($urandom_range(3) == 0);
			@(posedge clock_40);
			status  <= {63'd0, s_now};
			buttons <= {b_now, 1'b0};
			@(negedge clock_40);
			check_value("core_reset", 64'(s_d2 | b_d1), 64'(core_reset));
			s_d2 = s_d1;
			s_d1 = s_now;
			b_d1 = b_now;
		end
		@(posedge clock_40);
		buttons <= 2'b00;
	endtask

	task automatic map_joysticks();
		logic [31:0] j0;
		logic [31:0] j1;
		logic [31:0] j0_d1;
		logic [31:0] j1_d1;
		logic [63:0] st;
		logic [63:0] st_d1;
		logic [63:0] st_d2;
		j0_d1 = joystick_0;
		j1_d1 = joystick_1;
		st_d1 = status;
		st_d2 = status;
		for (int n = 0; n < 300; n++) begin
			j0 = $urandom;
			j1 = $urandom;
			st = {$urandom, $urandom};
			@(posedge clock_40);
			joystick_0 <= j0;
			joystick_1 <= j1;
			status     <= st;
			@(negedge clock_40);
			check_value("controls", 64'(expect_controls(j0_d1, j1_d1, st_d2[2], st_d2[6])),
				64'(controls));
			j0_d1 = j0;
			j1_d1 = j1;
			st_d2 = st_d1;
			st_d1 = st;
		end
	endtask

	// **************************************************
	// ROM fetch with a new address pair every cycle
	// **************************************************
	task automatic fetch_rom_bytes();
		logic [14:0] cpu_a;
		logic [13:0] spr_a;
		logic        dl;
		logic [13:0] cpu_d1;
		logic [13:0] cpu_d2;
		logic [14:0] spr_d1;
		logic [14:0] spr_d2;
		logic [1:0]  odd_d1;
		logic [1:0]  odd_d2;
		cpu_d1 = '0;
		spr_d1 = '0;
		odd_d1 = '0;
		for (int n = 0; n < 300; n++) begin
			cpu_a = 15'($urandom);
			spr_a = 14'($urandom);
			dl    = ($urandom_range(3) == 0);
			@(posedge clock_40);
			cpu_rom_addr <= cpu_a;
			spr_rom_addr <= spr_a;
			ioctl_downl  <= dl;
			cpu_rom_word <= sdram_word({1'b0, cpu_d1}, cpu_key); // Word for the address now on the bus
			spr_rom_word <= sdram_word(spr_d1, spr_key);
			@(negedge clock_40);
			if (n >= 1) begin
				check_value("rom_addr.cpu_addr", 64'(cpu_d1), 64'(rom_addr.cpu_addr));
				check_value("rom_addr.spr_addr", 64'(spr_d1), 64'(rom_addr.spr_addr));
			end
			if (n >= 2) begin
				check_value("cpu_rom_do", 64'(pick_byte(sdram_word({1'b0, cpu_d2}, cpu_key),
					odd_d2[1])), 64'(cpu_rom_do));
				check_value("spr_rom_do", 64'(pick_byte(sdram_word(spr_d2, spr_key), odd_d2[0])),
					64'(spr_rom_do));
			end
			cpu_d2 = cpu_d1;
			spr_d2 = spr_d1;
			odd_d2 = odd_d1;
			cpu_d1 = dl ? 14'h3FFF : cpu_a[14:1];
			spr_d1 = dl ? 15'h7FFF : 15'(spr_a >> 1) + spr_offset;
			odd_d1 = {cpu_a[0], spr_a[0]};
		end
		@(posedge clock_40);
		ioctl_downl <= 1'b0;
	endtask

	initial begin
		void'($urandom(95));
		$timeformat(-9, 0, " ns", 0);
		rst          = 1'b1;
		status       = '0;
		buttons      = '0;
		joystick_0   = '0;
		joystick_1   = '0;
		ioctl_downl  = 1'b0;
		ioctl_wr     = 1'b0;
		ioctl_index  = '0;
		ioctl_addr   = '0;
		ioctl_dout   = '0;
		cpu_rom_addr = '0;
		spr_rom_addr = '0;
		cpu_rom_word = '0;
		spr_rom_word = '0;
		repeat (16) @(posedge clock_40);
		rst <= 1'b0;
		@(negedge clock_40);
		check_value("port_req", 64'd0, 64'(port_req));
		check_value("dn_wr", 64'd0, 64'(dn_wr));
		check_value("core_reset", 64'd1, 64'(core_reset));
		check_value("controls", 64'h1FF, 64'(controls));
		check_value("options", 64'd0, 64'(options));
		check_value("dl_write.we", 64'd0, 64'(dl_write.we));
		check_value("cpu_rom_do", 64'd0, 64'(cpu_rom_do));
		check_value("spr_rom_do", 64'd0, 64'(spr_rom_do));
		decode_status_words();
		load_rom_burst();
		follow_reset_sources();
		map_joysticks();
		fetch_rom_bytes();
		$display("=== PASS ===");
		$finish;
	end

endmodule

// File: files.f
logic/cfg_pkg.sv
logic/mem_pkg.sv
logic/status_decode.sv
logic/rom_loader.sv
logic/input_mapper.sv
logic/rom_fetch.sv
logic/arcade_ctrl_top.sv
tests/tb_arcade_ctrl.sv

// File: run.sh
#!/bin/sh
# Compile the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
	-f files.f --top-module tb_arcade_ctrl -Mdir obj_dir \
	&& ./obj_dir/Vtb_arcade_ctrl | tee /dev/stderr | grep -F "=== PASS ===" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
